/* hdl/mem_pkg.sv */
////////////////////////////////////////
// shared types and constants for the
// load/store access block
////////////////////////////////////////

package mem_pkg;

  localparam int MEM_ADDR_W = 64;
  localparam int MEM_DATA_W = 64;

  // wait cycles allowed before a request is dropped
  localparam int MEM_TIMEOUT = 16;
  localparam int MEM_TMR_W = $clog2(MEM_TIMEOUT);

  // addr[31:28] of the uart window
  localparam logic [3:0] MEM_PERIPH_TAG = 4'h1;

  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_e;

  // byte count minus one
  typedef enum logic [2:0] {
    MEM_SIZE_B = 3'd0,
    MEM_SIZE_H = 3'd1,
    MEM_SIZE_W = 3'd3,
    MEM_SIZE_D = 3'd7
  } mem_size_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_WAIT = 2'd1,
    ST_DONE = 2'd2
  } mem_state_e;

  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
    mem_size_e             size;
    mem_op_e               op;
    logic [MEM_DATA_W-1:0] wdata;
  } mem_req_t;

endpackage

/* hdl/mem_access_fsm.sv */
////////////////////////////////////////
// access sequencer: issue, wait, done
////////////////////////////////////////

`timescale 1ns/1ps

module mem_access_fsm (
  input  logic clk,
  input  logic rst,
  input  logic i_start,
  input  logic i_ren,
  input  logic i_wen,
  input  logic i_xfer,
  input  logic i_expired,
  input  logic i_ack,
  output logic o_issue,
  output logic o_drop,
  output logic o_capture,
  output logic o_counting,
  output logic o_done,
  output logic o_err
);

  import mem_pkg::*;

  mem_state_e state_q;
  mem_state_e state_d;
  logic       err_q;
  logic       start_ok;

  // start only counts when idle and some enable is set
  assign start_ok = (state_q == ST_IDLE) && i_start && (i_ren || i_wen);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_ok) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        // transfer and timeout both finish the access
        if (i_xfer || i_expired) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        if (i_ack) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (o_drop) begin
        err_q <= 1'b1;
      end else if ((state_q == ST_DONE) && i_ack) begin
        err_q <= 1'b0;
      end
    end
  end

  assign o_issue    = start_ok;
  // a late transfer still wins over expiry
  assign o_capture  = (state_q == ST_WAIT) && i_xfer;
  assign o_drop     = (state_q == ST_WAIT) && i_expired && !i_xfer;
  assign o_counting = (state_q == ST_WAIT);
  assign o_done     = (state_q == ST_DONE);
  assign o_err      = err_q;

endmodule

/* hdl/mem_wait_timer.sv */
////////////////////////////////////////
// wait-cycle counter with timeout flag
////////////////////////////////////////

`timescale 1ns/1ps

module mem_wait_timer (
  input  logic clk,
  input  logic rst,
  input  logic i_counting,
  output logic o_expired
);

  import mem_pkg::*;

  logic [MEM_TMR_W-1:0] cnt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (!i_counting) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // high in the last allowed wait cycle, so req falls after
  // exactly MEM_TIMEOUT cycles
  assign o_expired = i_counting && (cnt_q == MEM_TMR_W'(MEM_TIMEOUT - 1));

endmodule

/* hdl/mem_port_router.sv */
////////////////////////////////////////
// address decode, port request registers
// and read data capture
////////////////////////////////////////

`timescale 1ns/1ps

module mem_port_router (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          i_issue,
  input  logic                          i_drop,
  input  logic                          i_capture,
  input  logic                          i_ren,
  input  mem_pkg::mem_req_t             i_req,
  input  logic                          i_dc_ack,
  input  logic [mem_pkg::MEM_DATA_W-1:0] i_dc_rdata,
  input  logic                          i_nc_ack,
  input  logic [mem_pkg::MEM_DATA_W-1:0] i_nc_rdata,
  output logic                          o_xfer,
  output logic                          o_dc_req,
  output mem_pkg::mem_req_t             o_dc_cmd,
  output logic                          o_nc_req,
  output mem_pkg::mem_req_t             o_nc_cmd,
  output logic [mem_pkg::MEM_DATA_W-1:0] o_raw_rdata,
  output mem_pkg::mem_size_e            o_size
);

  import mem_pkg::*;

  mem_req_t              cmd;
  mem_req_t              act_cmd;
  logic                  is_periph;
  logic                  sel_nc_q;
  logic [MEM_DATA_W-1:0] port_rdata;
  logic [MEM_DATA_W-1:0] raw_q;
  mem_size_e             size_q;

  // op comes from the enables, read wins
  always_comb begin
    cmd    = i_req;
    cmd.op = i_ren ? MEM_OP_READ : MEM_OP_WRITE;
  end

  assign is_periph = (i_req.addr[31:28] == MEM_PERIPH_TAG);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_dc_req <= 1'b0;
      o_nc_req <= 1'b0;
      sel_nc_q <= 1'b0;
    end else if (i_issue) begin
      o_dc_req <= !is_periph;
      o_nc_req <= is_periph;
      sel_nc_q <= is_periph;
    end else if (i_capture || i_drop) begin
      o_dc_req <= 1'b0;
      o_nc_req <= 1'b0;
    end
  end

  // command registers, only the chosen port is loaded
  always_ff @(posedge clk) begin
    if (i_issue && is_periph) begin
      o_nc_cmd <= cmd;
    end
    if (i_issue && !is_periph) begin
      o_dc_cmd <= cmd;
    end
  end

  assign act_cmd    = sel_nc_q ? o_nc_cmd : o_dc_cmd;
  assign port_rdata = sel_nc_q ? i_nc_rdata : i_dc_rdata;
  assign o_xfer     = sel_nc_q ? (o_nc_req && i_nc_ack) : (o_dc_req && i_dc_ack);

  // last captured data and size, kept for the formatter
  always_ff @(posedge clk) begin
    if (rst) begin
      raw_q  <= '0;
      size_q <= MEM_SIZE_D;
    end else if (i_capture) begin
      raw_q  <= o_raw_rdata;
      size_q <= act_cmd.size;
    end
  end

  // passes the port data through in the transfer cycle
  always_comb begin
    if (i_capture) begin
      o_raw_rdata = (act_cmd.op == MEM_OP_READ) ? port_rdata : '0;
      o_size      = act_cmd.size;
    end else begin
      o_raw_rdata = raw_q;
      o_size      = size_q;
    end
  end

endmodule

/* hdl/mem_load_format.sv */
////////////////////////////////////////
// load data zero-extension by size
////////////////////////////////////////

`timescale 1ns/1ps

module mem_load_format (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [mem_pkg::MEM_DATA_W-1:0] i_raw,
  input  mem_pkg::mem_size_e            i_size,
  output logic [mem_pkg::MEM_DATA_W-1:0] o_rdata
);

  import mem_pkg::*;

  logic [MEM_DATA_W-1:0] masked;
  logic [MEM_DATA_W-1:0] rdata_q;

  // keep only the accessed low bytes
  always_comb begin
    case (i_size)
      MEM_SIZE_B: begin
        masked = {{(MEM_DATA_W-8){1'b0}}, i_raw[7:0]};
      end
      MEM_SIZE_H: begin
        masked = {{(MEM_DATA_W-16){1'b0}}, i_raw[15:0]};
      end
      MEM_SIZE_W: begin
        masked = {{(MEM_DATA_W-32){1'b0}}, i_raw[31:0]};
      end
      MEM_SIZE_D: begin
        masked = i_raw;
      end
      default: begin
        masked = i_raw;
      end
    endcase
  end

  // registered at the edge after the transfer, alongside done
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata_q <= '0;
    end else begin
      rdata_q <= masked;
    end
  end

  assign o_rdata = rdata_q;

endmodule

/* hdl/mem_unit.sv */
////////////////////////////////////////
// load/store access block top level
////////////////////////////////////////

`timescale 1ns/1ps

module mem_unit (
  input  logic                          clk,
  input  logic                          rst,
  // requester
  input  logic                          i_start,
  input  logic                          i_ren,
  input  logic                          i_wen,
  input  mem_pkg::mem_req_t             i_req,
  input  logic                          i_ack,
  output logic                          o_done,
  output logic                          o_err,
  output logic [mem_pkg::MEM_DATA_W-1:0] o_rdata,
  // data cache
  output logic                          o_dc_req,
  output mem_pkg::mem_req_t             o_dc_cmd,
  input  logic                          i_dc_ack,
  input  logic [mem_pkg::MEM_DATA_W-1:0] i_dc_rdata,
  // uncached peripheral
  output logic                          o_nc_req,
  output mem_pkg::mem_req_t             o_nc_cmd,
  input  logic                          i_nc_ack,
  input  logic [mem_pkg::MEM_DATA_W-1:0] i_nc_rdata
);

  import mem_pkg::*;

  logic                  issue;
  logic                  drop;
  logic                  capture;
  logic                  counting;
  logic                  expired;
  logic                  xfer;
  logic [MEM_DATA_W-1:0] raw_rdata;
  mem_size_e             raw_size;

  mem_access_fsm fsm_i (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .i_ren      (i_ren),
    .i_wen      (i_wen),
    .i_xfer     (xfer),
    .i_expired  (expired),
    .i_ack      (i_ack),
    .o_issue    (issue),
    .o_drop     (drop),
    .o_capture  (capture),
    .o_counting (counting),
    .o_done     (o_done),
    .o_err      (o_err)
  );

  mem_wait_timer timer_i (
    .clk        (clk),
    .rst        (rst),
    .i_counting (counting),
    .o_expired  (expired)
  );

  mem_port_router router_i (
    .clk         (clk),
    .rst         (rst),
    .i_issue     (issue),
    .i_drop      (drop),
    .i_capture   (capture),
    .i_ren       (i_ren),
    .i_req       (i_req),
    .i_dc_ack    (i_dc_ack),
    .i_dc_rdata  (i_dc_rdata),
    .i_nc_ack    (i_nc_ack),
    .i_nc_rdata  (i_nc_rdata),
    .o_xfer      (xfer),
    .o_dc_req    (o_dc_req),
    .o_dc_cmd    (o_dc_cmd),
    .o_nc_req    (o_nc_req),
    .o_nc_cmd    (o_nc_cmd),
    .o_raw_rdata (raw_rdata),
    .o_size      (raw_size)
  );

  mem_load_format format_i (
    .clk     (clk),
    .rst     (rst),
    .i_raw   (raw_rdata),
    .i_size  (raw_size),
    .o_rdata (o_rdata)
  );

endmodule

/* testbench/mem_unit_assert.sv */
////////////////////////////////////////
// port and done protocol assertions
////////////////////////////////////////

`timescale 1ns/1ps

module mem_unit_assert (
  input logic              clk,
  input logic              rst,
  input logic              i_ack,
  input logic              i_done,
  input logic              i_err,
  input logic              i_dc_req,
  input mem_pkg::mem_req_t i_dc_cmd,
  input logic              i_dc_ack,
  input logic              i_nc_req,
  input mem_pkg::mem_req_t i_nc_cmd,
  input logic              i_nc_ack
);

  import mem_pkg::*;

  logic xfer;

  assign xfer = (i_dc_req && i_dc_ack) || (i_nc_req && i_nc_ack);

  // waiting request holds until dropped with an error
  dc_hold_a : assert property (@(posedge clk) disable iff (rst)
    i_dc_req && !i_dc_ack |=> (i_dc_req && $stable(i_dc_cmd)) || i_err)
    else $error("cache request changed or fell without a transfer");

  nc_hold_a : assert property (@(posedge clk) disable iff (rst)
    i_nc_req && !i_nc_ack |=> (i_nc_req && $stable(i_nc_cmd)) || i_err)
    else $error("peripheral request changed or fell without a transfer");

  one_port_a : assert property (@(posedge clk) disable iff (rst)
    !(i_dc_req && i_nc_req))
    else $error("both port requests are high");

  done_after_xfer_a : assert property (@(posedge clk) disable iff (rst)
    xfer |=> i_done && !i_err)
    else $error("done did not follow a transfer");

  done_held_a : assert property (@(posedge clk) disable iff (rst)
    i_done && !i_ack |=> i_done)
    else $error("done fell before the acknowledge");

  done_fall_a : assert property (@(posedge clk) disable iff (rst)
    i_done && i_ack |=> !i_done && !i_err)
    else $error("done or err still high after the acknowledge");

  reset_a : assert property (@(posedge clk)
    rst |=> !i_done && !i_err && !i_dc_req && !i_nc_req)
    else $error("outputs not low after reset");

endmodule

bind mem_unit mem_unit_assert assert_i (
  .clk      (clk),
  .rst      (rst),
  .i_ack    (i_ack),
  .i_done   (o_done),
  .i_err    (o_err),
  .i_dc_req (o_dc_req),
  .i_dc_cmd (o_dc_cmd),
  .i_dc_ack (i_dc_ack),
  .i_nc_req (o_nc_req),
  .i_nc_cmd (o_nc_cmd),
  .i_nc_ack (i_nc_ack)
);

/* testbench/mem_unit_tb.sv */
////////////////////////////////////////
// testbench for mem_unit: clock, reset,
// port memory models, stimulus, watchdog
////////////////////////////////////////

`timescale 1ns/1ps

module mem_unit_tb;

  import mem_pkg::*;

  localparam logic [31:0] SEED = 32'h27bb_5a45;
  localparam int N_TESTS = 20;
  localparam int WATCH_CYCLES = N_TESTS * (MEM_TIMEOUT + 10) + 50;
  localparam int CHK_W = $bits(mem_req_t);

  logic clk;
  logic rst;
  logic i_start;
  logic i_ren;
  logic i_wen;
  logic i_ack;
  mem_req_t i_req;
  logic o_done;
  logic o_err;
  logic [MEM_DATA_W-1:0] o_rdata;
  logic dc_req;
  mem_req_t dc_cmd;
  logic dc_ack = 1'b0;
  logic [MEM_DATA_W-1:0] dc_rdata = '0;
  logic nc_req;
  mem_req_t nc_cmd;
  logic nc_ack = 1'b0;
  logic [MEM_DATA_W-1:0] nc_rdata = '0;
  logic nc_mute;

  integer tb_seed = SEED;
  integer dc_seed = SEED;
  integer nc_seed = SEED;
  bit msg_done = 1'b0;
  logic [63:0] dc_mem [256];
  logic [63:0] nc_mem [16];
  logic [63:0] sh_dc [256];
  logic [63:0] sh_nc [16];
  bit dc_busy = 1'b0;
  bit nc_busy = 1'b0;
  int dc_wait = 0;
  int nc_wait = 0;
  mem_size_e sizes [4] = '{MEM_SIZE_B, MEM_SIZE_H, MEM_SIZE_W, MEM_SIZE_D};

  mem_unit mem_unit_i (
    .clk        (clk),
    .rst        (rst),
    .i_start    (i_start),
    .i_ren      (i_ren),
    .i_wen      (i_wen),
    .i_req      (i_req),
    .i_ack      (i_ack),
    .o_done     (o_done),
    .o_err      (o_err),
    .o_rdata    (o_rdata),
    .o_dc_req   (dc_req),
    .o_dc_cmd   (dc_cmd),
    .i_dc_ack   (dc_ack),
    .i_dc_rdata (dc_rdata),
    .o_nc_req   (nc_req),
    .o_nc_cmd   (nc_cmd),
    .i_nc_ack   (nc_ack),
    .i_nc_rdata (nc_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset contents, unique per word
  function automatic logic [63:0] fill_word(input bit is_nc, input int idx);
    logic [63:0] tag;
    tag = is_nc ? 64'h5e00_0000_0000_0000 : 64'hdc00_0000_0000_0000;
    return tag | (64'(idx) * 64'h0000_0101_0001_0001);
  endfunction

  function automatic int word_index(input bit is_nc, input logic [63:0] addr);
    return is_nc ? int'(addr[6:3]) : int'(addr[10:3]);
  endfunction

  // zero-extend to size+1 low bytes
  function automatic logic [63:0] size_mask(input logic [63:0] data, input mem_size_e size);
    int nbytes;
    logic [63:0] keep;
    nbytes = int'(size) + 1;
    if (nbytes >= 8) begin
      keep = '1;
    end else begin
      keep = (64'd1 << (8 * nbytes)) - 64'd1;
    end
    return data & keep;
  endfunction

  task automatic value_error(input string name, input logic [CHK_W-1:0] got,
                             input logic [CHK_W-1:0] exp);
    $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    msg_done = 1'b1;
    $display("Testbench failed");
    $fatal(1, "value mismatch on %s", name);
  endtask

  task automatic plain_error(input string what);
    $display("%0t ns: %s", $time, what);
    msg_done = 1'b1;
    $display("Testbench failed");
    $fatal(1, "check failed");
  endtask

  // cache model, random ack delay of 0 to 5 cycles
  always @(negedge clk) begin
    if (rst || !dc_req) begin
      dc_ack  = 1'b0;
      dc_busy = 1'b0;
    end else if (!dc_busy) begin
      dc_busy = 1'b1;
      dc_wait = $unsigned($random(dc_seed)) % 6;
    end else if (dc_wait > 0) begin
      dc_wait = dc_wait - 1;
    end
    if (dc_busy && (dc_wait == 0) && !dc_ack) begin
      dc_ack   = 1'b1;
      dc_rdata = dc_mem[word_index(1'b0, dc_cmd.addr)];
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        dc_mem[i] <= fill_word(1'b0, i);
      end
    end else if (dc_req && dc_ack && (dc_cmd.op == MEM_OP_WRITE)) begin
      dc_mem[word_index(1'b0, dc_cmd.addr)] <= dc_cmd.wdata;
    end
  end

  // peripheral model, same timing, ack can be muted
  always @(negedge clk) begin
    if (rst || !nc_req) begin
      nc_ack  = 1'b0;
      nc_busy = 1'b0;
    end else if (!nc_busy) begin
      nc_busy = 1'b1;
      nc_wait = $unsigned($random(nc_seed)) % 6;
    end else if (nc_wait > 0) begin
      nc_wait = nc_wait - 1;
    end
    if (nc_busy && (nc_wait == 0) && !nc_ack && !nc_mute) begin
      nc_ack   = 1'b1;
      nc_rdata = nc_mem[word_index(1'b1, nc_cmd.addr)];
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        nc_mem[i] <= fill_word(1'b1, i);
      end
    end else if (nc_req && nc_ack && (nc_cmd.op == MEM_OP_WRITE)) begin
      nc_mem[word_index(1'b1, nc_cmd.addr)] <= nc_cmd.wdata;
    end
  end

  // one request from start to acknowledge
  task automatic run_access(input logic ren, input logic wen, input logic [63:0] addr,
                            input mem_size_e size, input logic [63:0] wdata,
                            input logic expect_err);
    mem_req_t req;
    mem_req_t exp_cmd;
    logic to_nc;
    logic [63:0] exp_data;
    int waited;
    int hold;
    int high_cnt;
    req.addr  = addr;
    req.size  = size;
    req.wdata = wdata;
    // op field is deliberately wrong, the enables decide
    req.op    = ren ? MEM_OP_WRITE : MEM_OP_READ;
    exp_cmd    = req;
    exp_cmd.op = ren ? MEM_OP_READ : MEM_OP_WRITE;
    to_nc = (addr[31:28] == MEM_PERIPH_TAG);
    @(negedge clk);
    i_start = 1'b1;
    i_ren   = ren;
    i_wen   = wen;
    i_req   = req;
    @(negedge clk);
    i_start = 1'b0;
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    assert (nc_req == to_nc) else value_error("o_nc_req", nc_req, to_nc);
    assert (dc_req == !to_nc) else value_error("o_dc_req", dc_req, !to_nc);
    if (to_nc) begin
      assert (nc_cmd == exp_cmd) else value_error("o_nc_cmd", nc_cmd, exp_cmd);
    end else begin
      assert (dc_cmd == exp_cmd) else value_error("o_dc_cmd", dc_cmd, exp_cmd);
    end
    if (expect_err) begin
      high_cnt = 0;
      while (nc_req) begin
        high_cnt++;
        if (high_cnt > MEM_TIMEOUT + 4) begin
          plain_error("peripheral request was never dropped");
        end
        @(negedge clk);
      end
      assert (high_cnt == MEM_TIMEOUT) else value_error("o_nc_req cycles", high_cnt, MEM_TIMEOUT);
    end
    waited = 0;
    while (!o_done) begin
      if (waited > MEM_TIMEOUT + 10) begin
        plain_error("o_done never rose after a request");
      end
      @(negedge clk);
      waited++;
    end
    assert (o_err == expect_err) else value_error("o_err", o_err, expect_err);
    if (!expect_err) begin
      exp_data = ren ? size_mask(to_nc ? sh_nc[word_index(1'b1, addr)]
                                       : sh_dc[word_index(1'b0, addr)], size) : '0;
      assert (o_rdata == exp_data) else value_error("o_rdata", o_rdata, exp_data);
      if (!ren && to_nc) begin
        sh_nc[word_index(1'b1, addr)] = wdata;
      end else if (!ren) begin
        sh_dc[word_index(1'b0, addr)] = wdata;
      end
    end
    // a start while done is high must be ignored
    i_start = 1'b1;
    i_ren   = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    i_ren   = 1'b0;
    assert (!dc_req && !nc_req) else plain_error("start while done raised a port request");
    assert (o_done) else value_error("o_done", o_done, 1'b1);
    hold = $unsigned($random(tb_seed)) % 4;
    repeat (hold) begin
      @(negedge clk);
      assert (o_done) else value_error("o_done", o_done, 1'b1);
    end
    i_ack = 1'b1;
    @(negedge clk);
    i_ack = 1'b0;
    assert (!o_done) else value_error("o_done", o_done, 1'b0);
    assert (!o_err) else value_error("o_err", o_err, 1'b0);
  endtask

  initial begin
    logic [63:0] base;
    logic [63:0] data;
    int p;
    int s;
    rst     = 1'b1;
    i_start = 1'b0;
    i_ren   = 1'b0;
    i_wen   = 1'b0;
    i_ack   = 1'b0;
    i_req   = '0;
    nc_mute = 1'b0;
    for (int i = 0; i < 256; i++) begin
      sh_dc[i] = fill_word(1'b0, i);
    end
    for (int i = 0; i < 16; i++) begin
      sh_nc[i] = fill_word(1'b1, i);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // both enables set reads
    run_access(1'b1, 1'b1, 64'h0000_0000_3000_0018, MEM_SIZE_D, 64'h0, 1'b0);
    for (p = 0; p < 2; p++) begin
      base = (p == 1) ? 64'h0000_00a5_1000_0000 : 64'h0000_0000_8000_0000;
      for (s = 0; s < 4; s++) begin
        data = {$random(tb_seed), $random(tb_seed)};
        run_access(1'b0, 1'b1, base + 64'(s * 8), sizes[s], data, 1'b0);
        run_access(1'b1, 1'b0, base + 64'(s * 8), sizes[s], 64'h0, 1'b0);
      end
    end

    // muted peripheral times out, then the cache still works
    nc_mute = 1'b1;
    run_access(1'b1, 1'b0, 64'h0000_0000_1000_0020, MEM_SIZE_W, 64'h0, 1'b1);
    nc_mute = 1'b0;
    run_access(1'b1, 1'b0, 64'h0000_0000_8000_0000, MEM_SIZE_D, 64'h0, 1'b0);

    @(negedge clk);
    i_start    = 1'b1;
    i_req.addr = 64'h0000_0000_8000_0008;
    @(negedge clk);
    i_start = 1'b0;
    repeat (20) begin
      assert (!dc_req && !nc_req && !o_done) else plain_error("start without enable did work");
      @(negedge clk);
    end
    msg_done = 1'b1;
    $display("Testbench passed");
    $finish;
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge clk);
    $display("run hung: not finished after %0d cycles", WATCH_CYCLES);
    msg_done = 1'b1;
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  // catches a stop from a failed bound assertion
  final begin
    if (!msg_done) begin
      $display("Testbench failed");
    end
  end

endmodule

/* files.f */
hdl/mem_pkg.sv
hdl/mem_access_fsm.sv
hdl/mem_wait_timer.sv
hdl/mem_port_router.sv
hdl/mem_load_format.sv
hdl/mem_unit.sv
testbench/mem_unit_assert.sv
testbench/mem_unit_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mem_unit_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
